// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [6:0]      opcode_t;

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // Immediate format of the instruction
    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N
    } inst_type_e;

    typedef enum logic {
        FETCH_REQ,
        FETCH_WAIT
    } fetch_state_e;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } fetched_t;

    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        opcode_t    opcode;
        inst_type_e inst_type;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_addr_t  rd;
        xlen_t      imm;
        xlen_t      src1;
        xlen_t      src2;
        csr_addr_t  csr_addr;
        xlen_t      csr_old;
        xlen_t      zimm;
    } decoded_t;

    typedef struct packed {
        logic      gpr_we;
        reg_addr_t rd;
        xlen_t     gpr_data;
        logic      csr_we;
        csr_addr_t csr_addr;
        xlen_t     csr_data;
    } writeback_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        logic      rd_we;
        reg_addr_t rd;
        xlen_t     rd_data;
    } retire_t;

endpackage

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output xlen_t     src1,
    output xlen_t     src2,
    input  logic      we,
    input  reg_addr_t rd,
    input  xlen_t     wdata
);

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    assign src1 = regs[rs1];
    assign src2 = regs[rs2];

    x0_zero_a: assert property (@(posedge clk) disable iff (!arst_n)
        ((rs1 != '0) || (src1 == '0)) && ((rs2 != '0) || (src2 == '0)));

endmodule

`default_nettype wire

// File: design/rv_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_csr_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  csr_addr_t raddr,
    output xlen_t     rdata,
    input  logic      we,
    input  csr_addr_t waddr,
    input  xlen_t     wdata
);

    xlen_t mtvec_q;
    xlen_t mscratch_q;
    xlen_t mepc_q;
    xlen_t mcause_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (we) begin
            case (waddr)
                CSR_MTVEC:    mtvec_q    <= wdata;
                CSR_MSCRATCH: mscratch_q <= wdata;
                CSR_MEPC:     mepc_q     <= wdata;
                CSR_MCAUSE:   mcause_q   <= wdata;
                default: ;
            endcase
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        case (raddr)
            CSR_MTVEC:    rdata = mtvec_q;
            CSR_MSCRATCH: rdata = mscratch_q;
            CSR_MEPC:     rdata = mepc_q;
            CSR_MCAUSE:   rdata = mcause_q;
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     redirect,
    input  xlen_t    next_pc,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output xlen_t    wb_adr,
    input  logic     wb_ack,
    input  inst_t    wb_dat_r,
    output fetched_t fetched
);

    fetch_state_e state_q;
    xlen_t        pc_q;
    logic         boot_q;
    logic         done;

    // Bus cycle is open for the whole request state
    assign wb_cyc = (state_q == FETCH_REQ);
    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b0;
    assign wb_adr = pc_q;
    assign done   = wb_cyc && wb_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= FETCH_WAIT;
            pc_q    <= '0;
            boot_q  <= 1'b1;
        end else begin
            boot_q <= 1'b0;
            case (state_q)
                FETCH_REQ: begin
                    if (wb_ack) begin
                        state_q <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    // First request after reset uses the reset PC
                    if (redirect) begin
                        state_q <= FETCH_REQ;
                        pc_q    <= next_pc;
                    end else if (boot_q) begin
                        state_q <= FETCH_REQ;
                    end
                end
                default: state_q <= FETCH_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetched <= '0;
        end else begin
            fetched.valid <= done;
            if (done) begin
                fetched.pc   <= pc_q;
                fetched.inst <= wb_dat_r;
            end
        end
    end

    // Request stays on the bus with a stable address until ack
    req_held_a: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && wb_cyc && $stable(wb_adr)));

    // Execute only redirects once the instruction has left the bus
    redirect_idle_a: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |-> (state_q == FETCH_WAIT));

endmodule

`default_nettype wire

// File: design/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  fetched_t   fetched,
    input  writeback_t wb,
    output decoded_t   decoded
);

    inst_t      inst;
    opcode_t    opcode;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    csr_addr_t  csr_addr;
    inst_type_e inst_type;
    xlen_t      imm;
    xlen_t      src1;
    xlen_t      src2;
    xlen_t      csr_old;

    assign inst     = fetched.inst;
    assign opcode   = inst[6:0];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign csr_addr = inst[31:20];

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC:             inst_type = TYPE_U;
            OPC_JAL:                        inst_type = TYPE_J;
            OPC_JALR, OPC_OP_IMM, OPC_SYSTEM: inst_type = TYPE_I;
            OPC_BRANCH:                     inst_type = TYPE_B;
            OPC_OP:                         inst_type = TYPE_R;
            default:                        inst_type = TYPE_N;
        endcase
    end

    always_comb begin
        case (inst_type)
            TYPE_I:  imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_S:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            TYPE_B:  imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            TYPE_U:  imm = {inst[31:12], 12'b0};
            TYPE_J:  imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    rv_regfile regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .src1   (src1),
        .src2   (src2),
        .we     (wb.gpr_we),
        .rd     (wb.rd),
        .wdata  (wb.gpr_data)
    );

    rv_csr_file csr_file_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (csr_addr),
        .rdata  (csr_old),
        .we     (wb.csr_we),
        .waddr  (wb.csr_addr),
        .wdata  (wb.csr_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decoded <= '0;
        end else begin
            decoded.valid     <= fetched.valid;
            decoded.pc        <= fetched.pc;
            decoded.opcode    <= opcode;
            decoded.inst_type <= inst_type;
            decoded.funct3    <= inst[14:12];
            decoded.funct7    <= inst[31:25];
            decoded.rd        <= inst[11:7];
            decoded.imm       <= imm;
            decoded.src1      <= src1;
            decoded.src2      <= src2;
            decoded.csr_addr  <= csr_addr;
            decoded.csr_old   <= csr_old;
            decoded.zimm      <= xlen_t'(rs1);
        end
    end

    // One instruction in flight, so operands never race a writeback
    single_issue_a: assert property (@(posedge clk) disable iff (!arst_n)
        !(fetched.valid && decoded.valid));

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  decoded_t   decoded,
    output writeback_t wb,
    output logic       redirect,
    output xlen_t      next_pc,
    output retire_t    retire
);

    xlen_t      op_b;
    xlen_t      alu_out;
    xlen_t      sra_out;
    xlen_t      pc_plus4;
    xlen_t      operand;
    xlen_t      csr_new;
    xlen_t      result;
    logic       is_op;
    logic       is_csr;
    logic       alt;
    logic       taken;
    logic       rd_wr;
    logic       csr_wr;
    logic [4:0] shamt;

    assign is_op    = (decoded.inst_type == TYPE_R);
    assign is_csr   = (decoded.funct3[1:0] != 2'b00);
    assign op_b     = is_op ? decoded.src2 : decoded.imm;
    assign shamt    = op_b[4:0];
    assign alt      = decoded.funct7[5];
    assign sra_out  = $signed(decoded.src1) >>> shamt;
    assign pc_plus4 = decoded.pc + 32'd4;

    // Sub only exists in the register form
    always_comb begin
        case (decoded.funct3)
            3'b000:  alu_out = (is_op && alt) ? decoded.src1 - op_b : decoded.src1 + op_b;
            3'b001:  alu_out = decoded.src1 << shamt;
            3'b010:  alu_out = xlen_t'($signed(decoded.src1) < $signed(op_b));
            3'b011:  alu_out = xlen_t'(decoded.src1 < op_b);
            3'b100:  alu_out = decoded.src1 ^ op_b;
            3'b101:  alu_out = alt ? sra_out : decoded.src1 >> shamt;
            3'b110:  alu_out = decoded.src1 | op_b;
            default: alu_out = decoded.src1 & op_b;
        endcase
    end

    always_comb begin
        case (decoded.funct3)
            3'b000:  taken = (decoded.src1 == decoded.src2);
            3'b001:  taken = (decoded.src1 != decoded.src2);
            3'b100:  taken = ($signed(decoded.src1) < $signed(decoded.src2));
            3'b101:  taken = ($signed(decoded.src1) >= $signed(decoded.src2));
            3'b110:  taken = (decoded.src1 < decoded.src2);
            3'b111:  taken = (decoded.src1 >= decoded.src2);
            default: taken = 1'b0;
        endcase
    end

    assign operand = decoded.funct3[2] ? decoded.zimm : decoded.src1;

    always_comb begin
        case (decoded.funct3[1:0])
            2'b01:   csr_new = operand;
            2'b10:   csr_new = decoded.csr_old | operand;
            default: csr_new = decoded.csr_old & ~operand;
        endcase
    end

    // Unknown opcodes fall through with no write
    always_comb begin
        result  = '0;
        rd_wr   = 1'b0;
        csr_wr  = 1'b0;
        next_pc = pc_plus4;
        case (decoded.opcode)
            OPC_LUI: begin
                result = decoded.imm;
                rd_wr  = 1'b1;
            end
            OPC_AUIPC: begin
                result = decoded.pc + decoded.imm;
                rd_wr  = 1'b1;
            end
            OPC_JAL: begin
                result  = pc_plus4;
                rd_wr   = 1'b1;
                next_pc = decoded.pc + decoded.imm;
            end
            OPC_JALR: begin
                result  = pc_plus4;
                rd_wr   = 1'b1;
                next_pc = (decoded.src1 + decoded.imm) & ~xlen_t'(1);
            end
            OPC_BRANCH: begin
                if (taken) begin
                    next_pc = decoded.pc + decoded.imm;
                end
            end
            OPC_OP_IMM, OPC_OP: begin
                result = alu_out;
                rd_wr  = 1'b1;
            end
            OPC_SYSTEM: begin
                if (is_csr) begin
                    result = decoded.csr_old;
                    rd_wr  = 1'b1;
                    csr_wr = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign redirect = decoded.valid;

    always_comb begin
        wb.gpr_we   = decoded.valid && rd_wr && (decoded.rd != '0);
        wb.rd       = decoded.rd;
        wb.gpr_data = result;
        wb.csr_we   = decoded.valid && csr_wr;
        wb.csr_addr = decoded.csr_addr;
        wb.csr_data = csr_new;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire.valid   <= decoded.valid;
            retire.pc      <= decoded.pc;
            retire.rd_we   <= wb.gpr_we;
            retire.rd      <= decoded.rd;
            retire.rd_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    output logic    wb_cyc,
    output logic    wb_stb,
    output logic    wb_we,
    output xlen_t   wb_adr,
    input  logic    wb_ack,
    input  inst_t   wb_dat_r,
    output retire_t retire
);

    fetched_t   fetched;
    decoded_t   decoded;
    writeback_t wb;
    logic       redirect;
    xlen_t      next_pc;

    rv_fetch fetch_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .redirect (redirect),
        .next_pc  (next_pc),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .fetched  (fetched)
    );

    rv_decode decode_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .fetched (fetched),
        .wb      (wb),
        .decoded (decoded)
    );

    rv_execute execute_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .decoded  (decoded),
        .wb       (wb),
        .redirect (redirect),
        .next_pc  (next_pc),
        .retire   (retire)
    );

endmodule

`default_nettype wire

// File: tests/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_INSTS      = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSTS * 8;

    // RV32I major opcodes
    localparam logic [6:0] ISA_LUI    = 7'h37;
    localparam logic [6:0] ISA_AUIPC  = 7'h17;
    localparam logic [6:0] ISA_JAL    = 7'h6f;
    localparam logic [6:0] ISA_JALR   = 7'h67;
    localparam logic [6:0] ISA_BRANCH = 7'h63;
    localparam logic [6:0] ISA_OP_IMM = 7'h13;
    localparam logic [6:0] ISA_OP     = 7'h33;
    localparam logic [6:0] ISA_SYSTEM = 7'h73;
    localparam logic [6:0] ISA_LOAD   = 7'h03;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    retire_t     retire;

    logic [31:0] lfsr;
    logic [31:0] xreg [32];
    logic [31:0] mcsr [4];
    logic [31:0] model_pc;
    logic [31:0] req_adr;
    logic [31:0] inst;
    logic [31:0] exp_data;
    logic [31:0] exp_next;
    logic        exp_write;
    int          waits;
    int          errors;
    int          retired;
    int          cycle_count;

    rv_core dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .retire   (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [11:0] pick_csr(input logic [2:0] sel);
        case (sel)
            3'd0:    return 12'h305;
            3'd1:    return 12'h340;
            3'd2:    return 12'h341;
            3'd3:    return 12'h342;
            default: return 12'h7c0;
        endcase
    endfunction

    function automatic int csr_slot(input logic [11:0] addr);
        case (addr)
            12'h305: return 0;
            12'h340: return 1;
            12'h341: return 2;
            12'h342: return 3;
            default: return -1;
        endcase
    endfunction

    function automatic logic [31:0] make_inst();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [19:0] upper;
        logic        alt;
        kind  = 4'(rand_bits(4));
        rd    = 5'(rand_bits(5));
        rs1   = 5'(rand_bits(5));
        rs2   = 5'(rand_bits(5));
        f3    = 3'(rand_bits(3));
        imm   = 12'(rand_bits(12));
        upper = 20'(rand_bits(20));
        alt   = 1'(rand_bits(1));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3: begin
                // Shift immediates carry only the shamt and the sra bit
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'b0;
                end else if (f3 == 3'b101) begin
                    imm[11:5] = {1'b0, alt, 5'b0};
                end
                return {imm, rs1, f3, rd, ISA_OP_IMM};
            end
            4'd4, 4'd5, 4'd15: begin
                if (f3 != 3'b000 && f3 != 3'b101) begin
                    alt = 1'b0;
                end
                return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, ISA_OP};
            end
            4'd6:  return {upper, rd, ISA_LUI};
            4'd7:  return {upper, rd, ISA_AUIPC};
            4'd8:  return {upper, rd, ISA_JAL};
            4'd9:  return {imm, rs1, 3'b000, rd, ISA_JALR};
            4'd10, 4'd11: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                return {imm[11:5], rs2, rs1, f3, imm[4:0], ISA_BRANCH};
            end
            4'd12, 4'd13: begin
                if (f3[1:0] == 2'b00) begin
                    f3[0] = 1'b1;
                end
                return {pick_csr(3'(rand_bits(3))), rs1, f3, rd, ISA_SYSTEM};
            end
            default: return {upper, rd, ISA_LOAD};
        endcase
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: begin
                if (alt) begin
                    return a - b;
                end
                return a + b;
            end
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic model_execute(input logic [31:0] word, output logic writes,
                                 output logic [31:0] data, output logic [31:0] npc);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] opnd;
        logic [31:0] old;
        logic        alt;
        int          slot;
        f3    = word[14:12];
        rd    = word[11:7];
        a     = xreg[word[19:15]];
        b     = xreg[word[24:20]];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        alt   = word[30] && (word[6:0] == ISA_OP || f3 == 3'b101);
        writes = 1'b0;
        data   = '0;
        npc    = model_pc + 32'd4;
        case (word[6:0])
            ISA_LUI: begin
                writes = 1'b1;
                data   = {word[31:12], 12'b0};
            end
            ISA_AUIPC: begin
                writes = 1'b1;
                data   = model_pc + {word[31:12], 12'b0};
            end
            ISA_JAL: begin
                writes = 1'b1;
                data   = model_pc + 32'd4;
                npc    = model_pc + imm_j;
            end
            ISA_JALR: begin
                writes = 1'b1;
                data   = model_pc + 32'd4;
                npc    = (a + imm_i) & 32'hffff_fffe;
            end
            ISA_BRANCH: begin
                if (branch_taken(f3, a, b)) begin
                    npc = model_pc + imm_b;
                end
            end
            ISA_OP_IMM: begin
                writes = 1'b1;
                data   = alu(f3, alt, a, imm_i);
            end
            ISA_OP: begin
                writes = 1'b1;
                data   = alu(f3, alt, a, b);
            end
            ISA_SYSTEM: begin
                if (f3[1:0] != 2'b00) begin
                    slot   = csr_slot(word[31:20]);
                    old    = (slot >= 0) ? mcsr[slot] : 32'd0;
                    opnd   = f3[2] ? {27'd0, word[19:15]} : a;
                    writes = 1'b1;
                    data   = old;
                    if (slot >= 0) begin
                        case (f3[1:0])
                            2'b01:   mcsr[slot] = opnd;
                            2'b10:   mcsr[slot] = old | opnd;
                            default: mcsr[slot] = old & ~opnd;
                        endcase
                    end
                end
            end
            default: ;
        endcase
        if (writes && rd != 5'd0) begin
            xreg[rd] = data;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Mismatch %s at pc %h: got %h, expected %h", name, req_adr, got, expected);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s (pc %h)", msg, req_adr);
        errors++;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run did not finish within %0d cycles, %0d instructions retired",
                 TIMEOUT_CYCLES, retired);
        $display("Verification failed");
        $finish;
    end

    initial begin
        errors   = 0;
        retired  = 0;
        lfsr     = 32'h19e9;
        model_pc = '0;
        req_adr  = '0;
        for (int i = 0; i < 32; i++) begin
            xreg[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            mcsr[i] = '0;
        end
        arst_n   = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_r = '0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (wb_cyc || wb_stb || retire.valid) begin
                report_failure("Bus cycle or retire active during reset");
            end
        end
        arst_n = 1'b1;
        if (wb_cyc || wb_stb || retire.valid) begin
            report_failure("Bus cycle or retire active right after reset");
        end

        for (int n = 0; n < NUM_INSTS; n++) begin
            while (!wb_cyc) begin
                @(negedge clk);
            end
            if (!wb_stb || wb_we) begin
                report_failure("Request without stb or with we set");
            end
            if (wb_adr !== model_pc) begin
                report_mismatch("wb_adr", wb_adr, model_pc);
            end
            req_adr = wb_adr;
            waits   = int'(rand_bits(2));
            inst    = make_inst();
            for (int w = 0; w < waits; w++) begin
                @(negedge clk);
                if (!wb_cyc || wb_adr !== req_adr) begin
                    report_failure("Request dropped or address changed in a wait state");
                end
            end
            wb_ack   = 1'b1;
            wb_dat_r = inst;
            model_execute(inst, exp_write, exp_data, exp_next);
            @(negedge clk);
            wb_ack = 1'b0;
            if (wb_cyc) begin
                report_failure("Bus cycle still open after ack");
            end
            // Retire lands exactly three cycles after the ack cycle
            for (int k = 0; k < 2; k++) begin
                if (retire.valid) begin
                    report_failure("Retire arrived early");
                end
                @(negedge clk);
            end
            if (retire.valid !== 1'b1) begin
                report_mismatch("retire.valid", 32'(retire.valid), 32'd1);
            end
            if (retire.pc !== req_adr) begin
                report_mismatch("retire.pc", retire.pc, req_adr);
            end
            if (retire.rd_we !== (exp_write && inst[11:7] != 5'd0)) begin
                report_mismatch("retire.rd_we", 32'(retire.rd_we),
                                32'(exp_write && inst[11:7] != 5'd0));
            end
            if (exp_write && retire.rd !== inst[11:7]) begin
                report_mismatch("retire.rd", 32'(retire.rd), 32'(inst[11:7]));
            end
            if (exp_write && retire.rd_data !== exp_data) begin
                report_mismatch("retire.rd_data", retire.rd_data, exp_data);
            end
            retired++;
            model_pc = exp_next;
        end

        $display("Retired %0d instructions with %0d errors", retired, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_csr_file.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_core.sv
tests/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f verilog.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" <<< "$output"; then
    exit 0
fi
exit 1
